//--- dcache_subsystem.f
design/dcache_pkg.sv
design/dcache_bram.sv
design/dcache_controller.sv
design/dcache_stats.sv
design/dcache_subsystem.sv
verif/dcache_chk.sv
verif/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache_subsystem

sources:
  # Cache RTL, package first
  - files:
      - design/dcache_pkg.sv
      - design/dcache_bram.sv
      - design/dcache_controller.sv
      - design/dcache_stats.sv
      - design/dcache_subsystem.sv

  # Bound checker and testbench
  - target: simulation
    files:
      - verif/dcache_chk.sv
      - verif/dcache_tb.sv

//--- verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
	import dcache_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int RANDOM_ACCESSES = 400;
	localparam int MEM_WORDS = 1024;

	logic i_clock;
	logic i_reset;
	logic i_rw;
	logic i_request;
	logic i_flush;
	logic i_cacheable;
	logic [31:0] i_address;
	logic [DCACHE_WORD_BITS-1:0] i_wdata;
	logic o_ready;
	logic [DCACHE_WORD_BITS-1:0] o_rdata;
	logic o_bus_rw;
	logic o_bus_request;
	logic i_bus_ready;
	logic [31:0] o_bus_address;
	logic [DCACHE_WORD_BITS-1:0] i_bus_rdata;
	logic [DCACHE_WORD_BITS-1:0] o_bus_wdata;
	logic [DCACHE_STAT_BITS-1:0] o_hit_count;
	logic [DCACHE_STAT_BITS-1:0] o_miss_count;

	integer seed;

	// Bus memory and the model's view of it, indexed by address bits 11:2
	logic [DCACHE_WORD_BITS-1:0] bus_mem [MEM_WORDS];
	logic [DCACHE_WORD_BITS-1:0] ref_mem [MEM_WORDS];

	// Reference cache lines
	logic ref_valid [DCACHE_LINES];
	logic ref_dirty [DCACHE_LINES];
	logic [31:0] ref_line_addr [DCACHE_LINES];
	logic [DCACHE_WORD_BITS-1:0] ref_data [DCACHE_LINES];
	logic [DCACHE_STAT_BITS-1:0] ref_hits;
	logic [DCACHE_STAT_BITS-1:0] ref_misses;

	// Predicted bus accesses, oldest first
	logic exp_rw_q [$];
	logic [31:0] exp_addr_q [$];
	logic [DCACHE_WORD_BITS-1:0] exp_data_q [$];

	dcache_subsystem DUT (.*);

	always #20 i_clock = ~i_clock;

	// =========================================================================
	// Checks
	// =========================================================================

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [DCACHE_WORD_BITS-1:0] actual,
		input logic [DCACHE_WORD_BITS-1:0] expected);
		if (actual !== expected) begin
			stop_run($sformatf("CHECK FAILED at %0t ns: %s = %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_count(input string name, input logic [DCACHE_STAT_BITS-1:0] actual,
		input logic [DCACHE_STAT_BITS-1:0] expected);
		if (actual !== expected) begin
			stop_run($sformatf("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_stats();
		@(negedge i_clock);
		check_count("o_hit_count", o_hit_count, ref_hits);
		check_count("o_miss_count", o_miss_count, ref_misses);
	endtask

	task automatic compare_memory();
		@(negedge i_clock);
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_word($sformatf("bus_mem[%0d]", i), bus_mem[i], ref_mem[i]);
		end
	endtask

	// =========================================================================
	// Reference model
	// =========================================================================

	function automatic logic [DCACHE_WORD_BITS-1:0] fill_word(input logic [9:0] word);
		return {word, 12'h5a3, word} ^ 32'h8d00_0000;
	endfunction

	function automatic void expect_bus(input logic op_rw, input logic [31:0] addr,
		input logic [DCACHE_WORD_BITS-1:0] data);
		exp_rw_q.push_back(op_rw);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endfunction

	// Direct-mapped, write-back, write-allocate; the tag is the whole word address
	function automatic void ref_access(
		input logic op_rw,
		input logic [31:0] addr,
		input logic [DCACHE_WORD_BITS-1:0] data,
		output logic [DCACHE_WORD_BITS-1:0] exp_rdata,
		output logic exp_hit,
		output logic victim_wb,
		output logic [31:0] victim_addr,
		output logic [DCACHE_WORD_BITS-1:0] victim_data
	);
		int idx;
		idx = addr[2 +: DCACHE_INDEX_BITS];
		exp_hit = ref_valid[idx] && (ref_line_addr[idx] == addr);
		victim_wb = ref_valid[idx] && ref_dirty[idx] && !exp_hit;
		victim_addr = ref_line_addr[idx];
		victim_data = ref_data[idx];
		if (victim_wb) begin
			ref_mem[victim_addr[11:2]] = victim_data;
		end
		if (exp_hit) begin
			ref_hits = ref_hits + 1'b1;
		end else begin
			ref_misses = ref_misses + 1'b1;
		end
		if (op_rw) begin
			ref_data[idx] = data;
			ref_dirty[idx] = 1'b1;
		end else if (!exp_hit) begin
			// Refill lands clean
			ref_data[idx] = ref_mem[addr[11:2]];
			ref_dirty[idx] = 1'b0;
		end
		ref_valid[idx] = 1'b1;
		ref_line_addr[idx] = addr;
		exp_rdata = ref_data[idx];
	endfunction

	// Dirty lines go back in index order, clean lines stay valid
	function automatic void ref_flush();
		for (int i = 0; i < DCACHE_LINES; i++) begin
			if (ref_valid[i] && ref_dirty[i]) begin
				expect_bus(1'b1, ref_line_addr[i], ref_data[i]);
				ref_mem[ref_line_addr[i][11:2]] = ref_data[i];
				ref_valid[i] = 1'b0;
				ref_dirty[i] = 1'b0;
			end
		end
	endfunction

	// Eight tags over four indices, so lines keep evicting each other
	function automatic logic [31:0] pick_cached_address();
		logic [31:0] r;
		r = $random(seed);
		return {21'h0, r[2:0], r[4:3], 4'b0101, 2'b00};
	endfunction

	// Upper half of the memory, never cached
	function automatic logic [31:0] pick_uncached_address();
		logic [31:0] r;
		r = $random(seed);
		return {20'h0, 1'b1, r[8:0], 2'b00};
	endfunction

	// =========================================================================
	// Bus slave
	// =========================================================================

	task automatic serve_bus();
		int delay;
		int cycles;
		logic [9:0] word;
		if (exp_rw_q.size() == 0) begin
			stop_run($sformatf("Unexpected bus access to %h at %0t ns", o_bus_address, $time));
		end else begin
			check_word("o_bus_rw", {31'h0, o_bus_rw}, {31'h0, exp_rw_q[0]});
			check_word("o_bus_address", o_bus_address, exp_addr_q[0]);
			if (o_bus_rw) begin
				check_word("o_bus_wdata", o_bus_wdata, exp_data_q[0]);
			end
			void'(exp_rw_q.pop_front());
			void'(exp_addr_q.pop_front());
			void'(exp_data_q.pop_front());
			word = o_bus_address[11:2];
			delay = 1 + ($random(seed) & 3);
			repeat (delay) @(posedge i_clock);
			i_bus_ready <= 1'b1;
			if (o_bus_rw) begin
				bus_mem[word] = o_bus_wdata;
			end else begin
				i_bus_rdata <= bus_mem[word];
			end
			@(posedge i_clock);
			i_bus_ready <= 1'b0;
			cycles = 0;
			@(negedge i_clock);
			while (o_bus_request && cycles < TIMEOUT_CYCLES) begin
				@(negedge i_clock);
				cycles++;
			end
			if (o_bus_request) begin
				stop_run("Bus request was not released after i_bus_ready");
			end
		end
	endtask

	always @(negedge i_clock) begin
		if (o_bus_request === 1'b1) begin
			serve_bus();
		end
	end

	// =========================================================================
	// CPU-side stimulus
	// =========================================================================

	task automatic wait_ready(output logic [DCACHE_WORD_BITS-1:0] result);
		int cycles;
		cycles = 0;
		result = '0;
		@(negedge i_clock);
		while (!o_ready && cycles < TIMEOUT_CYCLES) begin
			@(negedge i_clock);
			cycles++;
		end
		if (!o_ready) begin
			stop_run("Timeout waiting for o_ready");
		end else begin
			result = o_rdata;
		end
	endtask

	task automatic run_access(input logic op_rw, input logic op_cacheable, input logic op_flush,
		input logic [31:0] addr, input logic [DCACHE_WORD_BITS-1:0] data,
		output logic [DCACHE_WORD_BITS-1:0] result);
		@(posedge i_clock);
		i_rw <= op_rw;
		i_cacheable <= op_cacheable;
		i_flush <= op_flush;
		i_address <= addr;
		i_wdata <= data;
		i_request <= 1'b1;
		wait_ready(result);
		@(posedge i_clock);
		i_request <= 1'b0;
		i_flush <= 1'b0;
		if (exp_rw_q.size() != 0) begin
			stop_run("A predicted bus access never happened");
		end
	endtask

	task automatic run_cached(input logic op_rw, input logic [31:0] addr,
		input logic [DCACHE_WORD_BITS-1:0] data);
		logic [DCACHE_WORD_BITS-1:0] exp_rdata;
		logic exp_hit;
		logic victim_wb;
		logic [31:0] victim_addr;
		logic [DCACHE_WORD_BITS-1:0] victim_data;
		logic [DCACHE_WORD_BITS-1:0] result;
		ref_access(op_rw, addr, data, exp_rdata, exp_hit, victim_wb, victim_addr, victim_data);
		if (victim_wb) begin
			expect_bus(1'b1, victim_addr, victim_data);
		end
		if (!op_rw && !exp_hit) begin
			expect_bus(1'b0, addr, 'x);
		end
		run_access(op_rw, 1'b1, 1'b0, addr, data, result);
		if (!op_rw) begin
			check_word("o_rdata", result, exp_rdata);
		end
		check_stats();
	endtask

	task automatic run_uncached(input logic op_rw, input logic [31:0] addr,
		input logic [DCACHE_WORD_BITS-1:0] data);
		logic [DCACHE_WORD_BITS-1:0] expected;
		logic [DCACHE_WORD_BITS-1:0] result;
		expect_bus(op_rw, addr, data);
		if (op_rw) begin
			ref_mem[addr[11:2]] = data;
		end
		expected = ref_mem[addr[11:2]];
		run_access(op_rw, 1'b0, 1'b0, addr, data, result);
		if (!op_rw) begin
			check_word("o_rdata", result, expected);
		end
	endtask

	task automatic run_flush();
		logic [DCACHE_WORD_BITS-1:0] result;
		ref_flush();
		run_access(1'b0, 1'b1, 1'b1, 32'h0, '0, result);
		compare_memory();
	endtask

	initial begin : stimulus
		int choice;
		logic [DCACHE_WORD_BITS-1:0] data;
		seed = 32'h8d00;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_rw = 1'b0;
		i_request = 1'b0;
		i_flush = 1'b0;
		i_cacheable = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		ref_hits = '0;
		ref_misses = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			bus_mem[i] = fill_word(i[9:0]);
			ref_mem[i] = fill_word(i[9:0]);
		end
		for (int i = 0; i < DCACHE_LINES; i++) begin
			ref_valid[i] = 1'b0;
			ref_dirty[i] = 1'b0;
			ref_line_addr[i] = '0;
			ref_data[i] = '0;
		end
		repeat (10) @(posedge i_clock);
		i_reset <= 1'b0;

		// First request lands while the init sweep still runs
		run_uncached(1'b1, 32'h0000_0a40, 32'hcafe_0001);
		run_uncached(1'b0, 32'h0000_0a40, '0);
		run_uncached(1'b0, 32'h0000_0c14, '0);

		// Read miss, then a hit on the same word
		run_cached(1'b0, 32'h0000_0114, '0);
		run_cached(1'b0, 32'h0000_0114, '0);

		// Write allocate stays in the cache
		run_cached(1'b1, 32'h0000_0254, 32'h1234_5678);
		run_cached(1'b0, 32'h0000_0254, '0);
		check_word("bus_mem[0x095]", bus_mem[10'h095], fill_word(10'h095));

		// Conflicts on dirty lines, read and write
		run_cached(1'b0, 32'h0000_0354, '0);
		run_cached(1'b1, 32'h0000_0114, 32'h0bad_f00d);
		run_cached(1'b1, 32'h0000_0514, 32'h5555_aaaa);
		run_cached(1'b1, 32'h0000_0094, 32'h7777_0000);

		// Only the lines that were dirty miss after a flush
		run_flush();
		run_cached(1'b0, 32'h0000_0354, '0);
		run_cached(1'b0, 32'h0000_0514, '0);
		run_cached(1'b0, 32'h0000_0094, '0);

		for (int n = 0; n < RANDOM_ACCESSES; n++) begin
			choice = $random(seed) & 63;
			data = $random(seed);
			if (choice == 0) begin
				run_flush();
			end else if (choice < 8) begin
				run_uncached(choice[0], pick_uncached_address(), data);
			end else begin
				run_cached(choice[0], pick_cached_address(), data);
			end
		end

		run_flush();
		check_stats();
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- verif/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk
	import dcache_pkg::*;
(
	input logic          i_clock,
	input logic          i_reset,
	input logic          i_ready,
	input logic          i_bus_request,
	input logic          i_bus_ready,
	input logic          i_bus_rw,
	input logic [31:0]   i_bus_address,
	input dcache_state_t i_state
);

	// Ready is a single-cycle pulse
	ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |=> !i_ready)
		else $error("o_ready stayed high for two cycles");

	// Bus request and its address hold until the bus answers
	bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=>
		(i_bus_request && $stable(i_bus_address) && $stable(i_bus_rw)))
		else $error("bus request dropped or changed before i_bus_ready");

	reset_quiet: assert property (@(posedge i_clock)
		i_reset |=> (!i_ready && !i_bus_request))
		else $error("o_ready or o_bus_request high in the cycle after reset");

	// The init sweep never touches the bus
	init_no_bus: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_state == INITIALIZE) |-> !i_bus_request)
		else $error("bus request during INITIALIZE");

endmodule

bind dcache_controller dcache_chk u_chk (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_ready       (o_ready),
	.i_bus_request (o_bus_request),
	.i_bus_ready   (i_bus_ready),
	.i_bus_rw      (o_bus_rw),
	.i_bus_address (o_bus_address),
	.i_state       (state)
);

//--- design/dcache_subsystem.sv
`timescale 1ns/1ps

module dcache_subsystem
	import dcache_pkg::*;
(
	input  logic                        i_clock,
	input  logic                        i_reset,

	// CPU side
	input  logic                        i_rw,
	input  logic                        i_request,
	input  logic                        i_flush,
	input  logic                        i_cacheable,
	input  logic [31:0]                 i_address,
	input  logic [DCACHE_WORD_BITS-1:0] i_wdata,
	output logic                        o_ready,
	output logic [DCACHE_WORD_BITS-1:0] o_rdata,

	// Bus side
	output logic                        o_bus_rw,
	output logic                        o_bus_request,
	input  logic                        i_bus_ready,
	output logic [31:0]                 o_bus_address,
	input  logic [DCACHE_WORD_BITS-1:0] i_bus_rdata,
	output logic [DCACHE_WORD_BITS-1:0] o_bus_wdata,

	// Statistics
	output logic [DCACHE_STAT_BITS-1:0] o_hit_count,
	output logic [DCACHE_STAT_BITS-1:0] o_miss_count
);

	logic ram_we;
	logic [DCACHE_INDEX_BITS-1:0] ram_addr;
	logic [DCACHE_ENTRY_BITS-1:0] ram_wdata;
	logic [DCACHE_ENTRY_BITS-1:0] ram_rdata;
	logic stat_hit;
	logic stat_miss;

	dcache_controller u_ctrl (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_rw          (i_rw),
		.i_request     (i_request),
		.i_flush       (i_flush),
		.i_cacheable   (i_cacheable),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_rw      (o_bus_rw),
		.o_bus_request (o_bus_request),
		.i_bus_ready   (i_bus_ready),
		.o_bus_address (o_bus_address),
		.i_bus_rdata   (i_bus_rdata),
		.o_bus_wdata   (o_bus_wdata),
		.o_ram_we      (ram_we),
		.o_ram_addr    (ram_addr),
		.o_ram_wdata   (ram_wdata),
		.i_ram_rdata   (ram_rdata),
		.o_stat_hit    (stat_hit),
		.o_stat_miss   (stat_miss)
	);

	dcache_bram u_ram (
		.i_clock (i_clock),
		.i_we    (ram_we),
		.i_addr  (ram_addr),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

	dcache_stats u_stats (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_hit        (stat_hit),
		.i_miss       (stat_miss),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

endmodule

//--- design/dcache_stats.sv
`timescale 1ns/1ps

module dcache_stats
	import dcache_pkg::*;
(
	input  logic                        i_clock,
	input  logic                        i_reset,
	input  logic                        i_hit,
	input  logic                        i_miss,
	output logic [DCACHE_STAT_BITS-1:0] o_hit_count,
	output logic [DCACHE_STAT_BITS-1:0] o_miss_count
);

	// Slot 0 counts hits, slot 1 counts misses
	logic [1:0] events;
	logic [DCACHE_STAT_BITS-1:0] counts [2];

	assign events = {i_miss, i_hit};

	// Counters stick at all ones instead of wrapping
	always_ff @(posedge i_clock) begin
		for (int i = 0; i < 2; i++) begin
			if (i_reset) begin
				counts[i] <= '0;
			end else if (events[i] && (counts[i] != '1)) begin
				counts[i] <= counts[i] + 1'b1;
			end
		end
	end

	assign o_hit_count = counts[0];
	assign o_miss_count = counts[1];

endmodule

//--- design/dcache_controller.sv
`timescale 1ns/1ps

module dcache_controller
	import dcache_pkg::*;
(
	input  logic                         i_clock,
	input  logic                         i_reset,

	// CPU side
	input  logic                         i_rw,
	input  logic                         i_request,
	input  logic                         i_flush,
	input  logic                         i_cacheable,
	input  logic [31:0]                  i_address,
	input  logic [DCACHE_WORD_BITS-1:0]  i_wdata,
	output logic                         o_ready,
	output logic [DCACHE_WORD_BITS-1:0]  o_rdata,

	// Bus side
	output logic                         o_bus_rw,
	output logic                         o_bus_request,
	input  logic                         i_bus_ready,
	output logic [31:0]                  o_bus_address,
	input  logic [DCACHE_WORD_BITS-1:0]  i_bus_rdata,
	output logic [DCACHE_WORD_BITS-1:0]  o_bus_wdata,

	// Tag and data RAM
	output logic                         o_ram_we,
	output logic [DCACHE_INDEX_BITS-1:0] o_ram_addr,
	output logic [DCACHE_ENTRY_BITS-1:0] o_ram_wdata,
	input  logic [DCACHE_ENTRY_BITS-1:0] i_ram_rdata,

	// Statistics events
	output logic                         o_stat_hit,
	output logic                         o_stat_miss
);

	dcache_state_t state;

	// Extra top bit marks the end of a sweep
	logic [DCACHE_INDEX_BITS:0] sweep_ptr;
	logic sweep_done;

	logic entry_valid;
	logic entry_dirty;
	logic [DCACHE_TAG_MSB:DCACHE_TAG_LSB] entry_tag;
	logic [DCACHE_WORD_BITS-1:0] entry_data;
	logic entry_hit;
	logic victim_dirty;
	logic request_accept;
	logic sweep_addressing;

	function automatic logic [DCACHE_ENTRY_BITS-1:0] make_entry(
		input logic [DCACHE_WORD_BITS-1:0] data,
		input logic [31:0] address,
		input logic dirty
	);
		logic [DCACHE_ENTRY_BITS-1:0] entry;
		entry = '0;
		entry[DCACHE_DATA_MSB:DCACHE_DATA_LSB] = data;
		entry[DCACHE_TAG_MSB:DCACHE_TAG_LSB] = address[DCACHE_TAG_MSB:DCACHE_TAG_LSB];
		entry[DCACHE_DIRTY_BIT] = dirty;
		entry[DCACHE_VALID_BIT] = 1'b1;
		return entry;
	endfunction

	// Fields of the line the RAM is currently showing
	assign entry_valid = i_ram_rdata[DCACHE_VALID_BIT];
	assign entry_dirty = i_ram_rdata[DCACHE_DIRTY_BIT];
	assign entry_tag = i_ram_rdata[DCACHE_TAG_MSB:DCACHE_TAG_LSB];
	assign entry_data = i_ram_rdata[DCACHE_DATA_MSB:DCACHE_DATA_LSB];

	// Tag is the full word address, so a match means this exact word
	assign entry_hit = entry_valid && (entry_tag == i_address[DCACHE_TAG_MSB:DCACHE_TAG_LSB]);
	assign victim_dirty = entry_dirty && !entry_hit;

	assign request_accept = i_request && !o_ready;
	assign sweep_done = sweep_ptr[DCACHE_INDEX_BITS];

	assign sweep_addressing = (state == INITIALIZE) || (state == FLUSH_SETUP) ||
		(state == FLUSH_CHECK) || (state == FLUSH_WRITE) || (state == FLUSH_NEXT);

	assign o_ram_addr = sweep_addressing ? sweep_ptr[DCACHE_INDEX_BITS-1:0]
		: i_address[DCACHE_TAG_LSB +: DCACHE_INDEX_BITS];

	// =========================================================================
	// RAM write port, written in the same cycle the decision is made
	// =========================================================================

	always_comb begin
		o_ram_we = 1'b0;
		o_ram_wdata = make_entry(i_wdata, i_address, 1'b1);
		case (state)
			INITIALIZE: begin
				o_ram_we = !sweep_done;
				o_ram_wdata = DCACHE_INVALID_ENTRY;
			end
			IDLE: begin
				// Write hit on the hot line
				o_ram_we = request_accept && !i_flush && i_cacheable && i_rw && entry_hit;
			end
			WRITE_SETUP: begin
				o_ram_we = !victim_dirty;
			end
			WRITE_WAIT: begin
				o_ram_we = i_bus_ready;
			end
			READ_BUS_WAIT: begin
				// Refill lands clean
				o_ram_we = o_bus_request && i_bus_ready;
				o_ram_wdata = make_entry(i_bus_rdata, i_address, 1'b0);
			end
			FLUSH_WRITE: begin
				o_ram_we = i_bus_ready;
				o_ram_wdata = DCACHE_INVALID_ENTRY;
			end
			default: begin
			end
		endcase
	end

	// =========================================================================
	// Main FSM
	// =========================================================================

	always_ff @(posedge i_clock) begin
		o_ready <= 1'b0;
		o_stat_hit <= 1'b0;
		o_stat_miss <= 1'b0;

		case (state)
			INITIALIZE: begin
				if (sweep_done) begin
					state <= IDLE;
				end else begin
					sweep_ptr <= sweep_ptr + 1'b1;
				end
			end

			IDLE: begin
				if (request_accept) begin
					if (i_flush) begin
						sweep_ptr <= '0;
						state <= FLUSH_SETUP;
					end else if (i_cacheable) begin
						// Fast path when the RAM already shows the requested word
						if (entry_hit) begin
							if (!i_rw) begin
								o_rdata <= entry_data;
							end
							o_ready <= 1'b1;
							o_stat_hit <= 1'b1;
						end else begin
							state <= i_rw ? WRITE_SETUP : READ_SETUP;
						end
					end else begin
						o_bus_rw <= i_rw;
						o_bus_address <= i_address;
						o_bus_wdata <= i_wdata;
						o_bus_request <= 1'b1;
						state <= PASS_THROUGH;
					end
				end
			end

			PASS_THROUGH: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_rdata <= i_bus_rdata;
					o_ready <= 1'b1;
					state <= IDLE;
				end
			end

			// Bus must be quiet before the next line is examined
			FLUSH_SETUP: begin
				if (!i_bus_ready) begin
					if (sweep_done) begin
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						state <= FLUSH_CHECK;
					end
				end
			end

			FLUSH_CHECK: begin
				if (entry_dirty) begin
					o_bus_rw <= 1'b1;
					o_bus_address <= {entry_tag, 2'b00};
					o_bus_wdata <= entry_data;
					o_bus_request <= 1'b1;
					state <= FLUSH_WRITE;
				end else begin
					sweep_ptr <= sweep_ptr + 1'b1;
					state <= FLUSH_SETUP;
				end
			end

			FLUSH_WRITE: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					state <= FLUSH_NEXT;
				end
			end

			FLUSH_NEXT: begin
				sweep_ptr <= sweep_ptr + 1'b1;
				state <= FLUSH_SETUP;
			end

			WRITE_SETUP: begin
				if (victim_dirty) begin
					o_bus_rw <= 1'b1;
					o_bus_address <= {entry_tag, 2'b00};
					o_bus_wdata <= entry_data;
					o_bus_request <= 1'b1;
					state <= WRITE_WAIT;
				end else begin
					o_ready <= 1'b1;
					o_stat_hit <= entry_hit;
					o_stat_miss <= !entry_hit;
					state <= IDLE;
				end
			end

			// Victim written back, new word goes in on the same edge
			WRITE_WAIT: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_ready <= 1'b1;
					o_stat_miss <= 1'b1;
					state <= IDLE;
				end
			end

			READ_SETUP: begin
				if (entry_hit) begin
					o_rdata <= entry_data;
					o_ready <= 1'b1;
					o_stat_hit <= 1'b1;
					state <= IDLE;
				end else if (victim_dirty) begin
					o_bus_rw <= 1'b1;
					o_bus_address <= {entry_tag, 2'b00};
					o_bus_wdata <= entry_data;
					o_bus_request <= 1'b1;
					state <= READ_WB_WAIT;
				end else begin
					o_bus_rw <= 1'b0;
					o_bus_address <= i_address;
					o_bus_request <= 1'b1;
					state <= READ_BUS_WAIT;
				end
			end

			// Request drops for one cycle, then the read goes out
			READ_WB_WAIT: begin
				if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_bus_rw <= 1'b0;
					o_bus_address <= i_address;
					state <= READ_BUS_WAIT;
				end
			end

			READ_BUS_WAIT: begin
				if (!o_bus_request) begin
					o_bus_request <= 1'b1;
				end else if (i_bus_ready) begin
					o_bus_request <= 1'b0;
					o_rdata <= i_bus_rdata;
					o_ready <= 1'b1;
					o_stat_miss <= 1'b1;
					state <= IDLE;
				end
			end

			default: begin
				state <= IDLE;
			end
		endcase

		// Reset restarts the invalidation sweep
		if (i_reset) begin
			state <= INITIALIZE;
			sweep_ptr <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			o_stat_hit <= 1'b0;
			o_stat_miss <= 1'b0;
		end
	end

endmodule

//--- design/dcache_bram.sv
`timescale 1ns/1ps

module dcache_bram
	import dcache_pkg::*;
(
	input  logic                         i_clock,
	input  logic                         i_we,
	input  logic [DCACHE_INDEX_BITS-1:0] i_addr,
	input  logic [DCACHE_ENTRY_BITS-1:0] i_wdata,
	output logic [DCACHE_ENTRY_BITS-1:0] o_rdata
);

	// Tag and data share one word per line
	logic [DCACHE_ENTRY_BITS-1:0] mem [DCACHE_LINES];

	// Read-first port, output follows the address one cycle later
	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
		o_rdata <= mem[i_addr];
	end

endmodule

//--- design/dcache_pkg.sv
package dcache_pkg;

	// =========================================================================
	// Cache geometry
	// =========================================================================

	// Small index keeps the init and flush sweeps short
	localparam int DCACHE_INDEX_BITS = 6;
	localparam int DCACHE_LINES = 1 << DCACHE_INDEX_BITS;

	localparam int DCACHE_WORD_BITS = 32;
	localparam int DCACHE_ENTRY_BITS = 64;

	// =========================================================================
	// Entry layout: data in the upper word, word address and flags below
	// =========================================================================

	localparam int DCACHE_VALID_BIT = 0;
	localparam int DCACHE_DIRTY_BIT = 1;
	localparam int DCACHE_TAG_LSB = 2;
	localparam int DCACHE_TAG_MSB = 31;
	localparam int DCACHE_DATA_LSB = 32;
	localparam int DCACHE_DATA_MSB = 63;

	// Valid and dirty both clear
	localparam logic [DCACHE_ENTRY_BITS-1:0] DCACHE_INVALID_ENTRY = 64'h0000_0000_0000_0000;

	localparam int DCACHE_STAT_BITS = 32;

	// Controller states
	typedef enum logic [3:0] {
		INITIALIZE,
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		FLUSH_NEXT,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT
	} dcache_state_t;

endpackage
